// ==== logic/time_dmr_pkg.sv ====
package time_dmr_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Default sizes of the time-redundant ALU
    ////////////////////////////////////////////////////////////////////////////

    // Width of both operands and of the result word
    localparam int DEFAULT_DATA_WIDTH = 16;

    // ID width including the parity bit
    // The lower bits count requests, the top bit makes the whole ID even parity
    localparam int DEFAULT_ID_SIZE = 3;

    // Number of register stages in the ALU pipeline
    localparam int DEFAULT_PIPE_DEPTH = 3;

    ////////////////////////////////////////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////////////////////////////////////////

    // ALU operations, all computed in the first pipeline stage
    // MUL_LO keeps only the low half of the product
    typedef enum logic [2:0] {
        ADD    = 3'd0,
        SUB    = 3'd1,
        XOR    = 3'd2,
        AND    = 3'd3,
        SHL    = 3'd4,
        MUL_LO = 3'd5
    } alu_op_e;

    // States of the comparing end block
    // BASE holds nothing and waits for the first copy of a request
    // WAIT_FOR_VALID holds the first copy and waits for the second one
    // WAIT_FOR_READY holds a compared result that downstream has not taken yet
    typedef enum logic [1:0] {
        BASE,
        WAIT_FOR_READY,
        WAIT_FOR_VALID
    } dmr_state_e;

endpackage

// ==== logic/time_dmr_start.sv ====
`timescale 1ns/1ns

module time_dmr_start
    import time_dmr_pkg::*;
#(
    parameter int DataWidth = DEFAULT_DATA_WIDTH,
    parameter int IdSize    = DEFAULT_ID_SIZE
) (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 enable_i,

    // Request from upstream
    input  alu_op_e              op_i,
    input  logic [DataWidth-1:0] a_i,
    input  logic [DataWidth-1:0] b_i,
    input  logic                 valid_i,
    output logic                 ready_o,

    // Copies towards the ALU pipeline
    output alu_op_e              op_o,
    output logic [DataWidth-1:0] a_o,
    output logic [DataWidth-1:0] b_o,
    output logic [IdSize-1:0]    id_o,
    output logic                 valid_o,
    input  logic                 ready_i,

    // ID that the next accepted request will carry
    output logic [IdSize-1:0]    next_id_o
);

    logic                 busy_q;
    logic                 second_q;
    logic [IdSize-2:0]    seq_q;
    logic                 accept;
    logic                 issue;
    logic                 last_copy;
    alu_op_e              op_q;
    logic [DataWidth-1:0] a_q;
    logic [DataWidth-1:0] b_q;
    logic [IdSize-1:0]    id_q;

    // Only one request is held at a time, so a new one waits until both copies left
    assign ready_o = ~busy_q;
    assign accept  = valid_i & ready_o;
    assign issue   = valid_o & ready_i;

    // With redundancy off the first copy is also the last one
    assign last_copy = second_q | ~enable_i;

    // Parity on top makes every legal ID even parity as a whole
    assign next_id_o = {^seq_q, seq_q};

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy_q   <= 1'b0;
            second_q <= 1'b0;
            seq_q    <= '0;
        end else if (accept) begin
            busy_q   <= 1'b1;
            second_q <= 1'b0;
            seq_q    <= seq_q + 1'b1;
        end else if (issue) begin
            // Stay busy for copy two, otherwise release the request
            busy_q   <= ~last_copy;
            second_q <= ~last_copy;
        end
    end

    // Stored request, reissued unchanged for the second copy
    always_ff @(posedge clk_i) begin
        if (accept) begin
            op_q <= op_i;
            a_q  <= a_i;
            b_q  <= b_i;
            id_q <= next_id_o;
        end
    end

    assign op_o    = op_q;
    assign a_o     = a_q;
    assign b_o     = b_q;
    assign id_o    = id_q;
    assign valid_o = busy_q;

endmodule

// ==== logic/alu_pipeline.sv ====
`timescale 1ns/1ns

module alu_pipeline
    import time_dmr_pkg::*;
#(
    parameter int DataWidth = DEFAULT_DATA_WIDTH,
    parameter int IdSize    = DEFAULT_ID_SIZE,
    parameter int PipeDepth = DEFAULT_PIPE_DEPTH
) (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  alu_op_e              op_i,
    input  logic [DataWidth-1:0] a_i,
    input  logic [DataWidth-1:0] b_i,
    input  logic [IdSize-1:0]    id_i,
    input  logic                 valid_i,
    output logic                 ready_o,
    input  logic                 fault_inject_i,
    output logic [DataWidth-1:0] result_o,
    output logic [IdSize-1:0]    id_o,
    output logic                 valid_o,
    input  logic                 ready_i
);

    localparam int ShiftBits = $clog2(DataWidth);

    logic [DataWidth-1:0] alu_result;
    logic [DataWidth-1:0] fault_mask;
    logic                 advance;
    logic [PipeDepth-1:0] valid_q;
    logic [DataWidth-1:0] result_q [PipeDepth];
    logic [IdSize-1:0]    id_q [PipeDepth];

    // The whole operation is done before the first register
    always_comb begin
        case (op_i)
            ADD:     alu_result = a_i + b_i;
            SUB:     alu_result = a_i - b_i;
            XOR:     alu_result = a_i ^ b_i;
            AND:     alu_result = a_i & b_i;
            SHL:     alu_result = a_i << b_i[ShiftBits-1:0];
            MUL_LO:  alu_result = a_i * b_i;
            default: alu_result = '0;
        endcase
    end

    // Injected upset flips bit 0 of whatever enters stage one this cycle
    assign fault_mask = {{(DataWidth-1){1'b0}}, fault_inject_i};

    // All stages move together, and an empty last stage never blocks the chain
    assign advance = ready_i | ~valid_q[PipeDepth-1];
    assign ready_o = advance;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= '0;
        end else if (advance) begin
            valid_q[0] <= valid_i;
            for (int s = 1; s < PipeDepth; s++) begin
                valid_q[s] <= valid_q[s-1];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (advance) begin
            result_q[0] <= alu_result ^ fault_mask;
            id_q[0]     <= id_i;
            for (int s = 1; s < PipeDepth; s++) begin
                result_q[s] <= result_q[s-1];
                id_q[s]     <= id_q[s-1];
            end
        end
    end

    assign result_o = result_q[PipeDepth-1];
    assign id_o     = id_q[PipeDepth-1];
    assign valid_o  = valid_q[PipeDepth-1];

endmodule

// ==== logic/time_dmr_end.sv ====
`timescale 1ns/1ns

module time_dmr_end
    import time_dmr_pkg::*;
#(
    parameter int DataWidth = DEFAULT_DATA_WIDTH,
    parameter int IdSize    = DEFAULT_ID_SIZE
) (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 enable_i,
    input  logic [IdSize-1:0]    next_id_i,
    input  logic [DataWidth-1:0] data_i,
    input  logic [IdSize-1:0]    id_i,
    input  logic                 valid_i,
    output logic                 ready_o,
    output logic [DataWidth-1:0] data_o,
    output logic [IdSize-1:0]    id_o,
    output logic                 needs_retry_o,
    output logic                 valid_o,
    input  logic                 ready_i,
    output logic                 fault_detected_o
);

    localparam int SeqSize = IdSize - 1;
    localparam int NumSeq  = 2 ** SeqSize;

    logic [DataWidth-1:0] data_q;
    logic [IdSize-1:0]    id_q;
    logic                 data_same_in, id_same_in, full_same_in;
    logic                 data_same_q, id_same_q, full_same_q;
    logic                 take;
    logic                 second_copy;
    logic                 drop_in;
    dmr_state_e           state_d, state_q;
    logic [NumSeq-1:0]    seen_d, seen_q;
    logic                 fault_cand;
    logic                 fault_q;

    ////////////////////////////////////////////////////////////////////////////
    // Beat storage and comparison
    ////////////////////////////////////////////////////////////////////////////

    assign take         = valid_i & ready_o;
    assign data_same_in = (data_i == data_q);
    assign id_same_in   = (id_i == id_q);
    assign full_same_in = data_same_in & id_same_in;
    assign full_same_q  = data_same_q & id_same_q;

    // Copy two is the beat whose ID matches the held first copy
    assign second_copy = (state_q == WAIT_FOR_VALID) & id_same_in;

    // Bad parity or an ID that was already forwarded is never sent out again
    assign drop_in = (^id_i) | seen_q[id_i[SeqSize-1:0]];

    // Data of copy two is only compared, so a held result never changes under stall
    always_ff @(posedge clk_i) begin
        if (take) begin
            id_q <= id_i;
        end
        if (take && enable_i && !second_copy) begin
            data_q <= data_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Handshake FSM
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d       = state_q;
        valid_o       = 1'b0;
        ready_o       = 1'b1;
        needs_retry_o = 1'b0;
        data_o        = data_q;
        id_o          = id_q;
        if (!enable_i) begin
            // Single copies pass straight through
            state_d = BASE;
            valid_o = valid_i;
            ready_o = ready_i;
            data_o  = data_i;
            id_o    = id_i;
        end else begin
            case (state_q)
                BASE: begin
                    if (valid_i && !drop_in) begin
                        state_d = WAIT_FOR_VALID;
                    end
                end
                WAIT_FOR_VALID: begin
                    valid_o = valid_i;
                    if (id_same_in) begin
                        // Copy two is always absorbed, the result waits here if needed
                        needs_retry_o = valid_i & ~data_same_in;
                        if (valid_i) begin
                            state_d = ready_i ? BASE : WAIT_FOR_READY;
                        end
                    end else begin
                        // A new ID means copy two went missing, so send the held one flagged
                        needs_retry_o = valid_i;
                        ready_o       = ready_i;
                        if (valid_i && ready_i && drop_in) begin
                            state_d = BASE;
                        end
                    end
                end
                WAIT_FOR_READY: begin
                    valid_o       = 1'b1;
                    ready_o       = 1'b0;
                    needs_retry_o = ~data_same_q;
                    if (ready_i) begin
                        state_d = BASE;
                    end
                end
                default: state_d = BASE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Recently seen table and fault flag
    ////////////////////////////////////////////////////////////////////////////

    // The next ID from the start block is cleared ahead of its reuse
    always_comb begin
        seen_d = seen_q;
        seen_d[next_id_i[SeqSize-1:0]] = 1'b0;
        if (enable_i && valid_o && ready_i) begin
            seen_d[id_o[SeqSize-1:0]] = 1'b1;
        end
    end

    // Fault when neither the new beat nor the one before it matched its predecessor
    assign fault_cand       = enable_i & take & ~full_same_in & ~full_same_q;
    assign fault_detected_o = fault_cand & ~fault_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q     <= BASE;
            seen_q      <= '0;
            data_same_q <= 1'b1;
            id_same_q   <= 1'b1;
            fault_q     <= 1'b0;
        end else begin
            state_q <= state_d;
            seen_q  <= seen_d;
            if (!enable_i) begin
                // Start the comparison history clean once redundancy comes back
                data_same_q <= 1'b1;
                id_same_q   <= 1'b1;
                fault_q     <= 1'b0;
            end else if (take) begin
                data_same_q <= data_same_in;
                id_same_q   <= id_same_in;
                fault_q     <= fault_cand;
            end
        end
    end

endmodule

// ==== logic/time_dmr_alu.sv ====
`timescale 1ns/1ns

module time_dmr_alu
    import time_dmr_pkg::*;
#(
    parameter int DataWidth = DEFAULT_DATA_WIDTH,
    parameter int IdSize    = DEFAULT_ID_SIZE,
    parameter int PipeDepth = DEFAULT_PIPE_DEPTH
) (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 enable_i,
    input  logic                 fault_inject_i,
    input  alu_op_e              in_op_i,
    input  logic [DataWidth-1:0] in_a_i,
    input  logic [DataWidth-1:0] in_b_i,
    input  logic                 in_valid_i,
    output logic                 in_ready_o,
    output logic [DataWidth-1:0] out_data_o,
    output logic [IdSize-1:0]    out_id_o,
    output logic                 out_needs_retry_o,
    output logic                 out_valid_o,
    input  logic                 out_ready_i,
    output logic                 fault_detected_o
);

    // Issue side between start block and pipeline
    alu_op_e              issue_op;
    logic [DataWidth-1:0] issue_a, issue_b;
    logic [IdSize-1:0]    issue_id, next_id;
    logic                 issue_valid, issue_ready;

    // Result side between pipeline and end block
    logic [DataWidth-1:0] alu_result;
    logic [IdSize-1:0]    alu_id;
    logic                 alu_valid, alu_ready;

    time_dmr_start #(.DataWidth(DataWidth), .IdSize(IdSize)) i_start (
        .clk_i, .reset_i, .enable_i,
        .op_i(in_op_i), .a_i(in_a_i), .b_i(in_b_i), .valid_i(in_valid_i), .ready_o(in_ready_o),
        .op_o(issue_op), .a_o(issue_a), .b_o(issue_b), .id_o(issue_id),
        .valid_o(issue_valid), .ready_i(issue_ready), .next_id_o(next_id)
    );

    alu_pipeline #(.DataWidth(DataWidth), .IdSize(IdSize), .PipeDepth(PipeDepth)) i_alu (
        .clk_i, .reset_i, .op_i(issue_op), .a_i(issue_a), .b_i(issue_b), .id_i(issue_id),
        .valid_i(issue_valid), .ready_o(issue_ready), .fault_inject_i,
        .result_o(alu_result), .id_o(alu_id), .valid_o(alu_valid), .ready_i(alu_ready)
    );

    time_dmr_end #(.DataWidth(DataWidth), .IdSize(IdSize)) i_end (
        .clk_i, .reset_i, .enable_i, .next_id_i(next_id),
        .data_i(alu_result), .id_i(alu_id), .valid_i(alu_valid), .ready_o(alu_ready),
        .data_o(out_data_o), .id_o(out_id_o), .needs_retry_o(out_needs_retry_o),
        .valid_o(out_valid_o), .ready_i(out_ready_i), .fault_detected_o
    );

endmodule

// ==== testbench/time_dmr_alu_assertions.sv ====
`timescale 1ns/1ns

module time_dmr_alu_assertions
    import time_dmr_pkg::*;
#(
    parameter int DataWidth = DEFAULT_DATA_WIDTH,
    parameter int IdSize    = DEFAULT_ID_SIZE
) (
    input logic                 clk_i,
    input logic                 reset_i,
    input dmr_state_e           state_i,
    input logic [DataWidth-1:0] data_i,
    input logic [IdSize-1:0]    id_i,
    input logic                 retry_i,
    input logic                 valid_i,
    input logic                 ready_i,
    input logic                 fault_i
);

    // A stalled output beat keeps its payload and its retry flag until it is taken
    assert property (@(posedge clk_i) disable iff (reset_i)
        valid_i && !ready_i |=> valid_i && $stable(data_i) && $stable(id_i) && $stable(retry_i))
        else $error("Output beat of the end block changed while stalled");

    // Reset leaves the end block idle with nothing on its output
    assert property (@(posedge clk_i) reset_i |=> !valid_i && state_i == BASE)
        else $error("End block presents a beat right after reset");

    // The fault flag is a single-cycle pulse
    assert property (@(posedge clk_i) disable iff (reset_i) fault_i |=> !fault_i)
        else $error("fault_detected_o stayed high for two cycles");

endmodule

// ==== testbench/time_dmr_alu_tb.sv ====
`timescale 1ns/1ns

module time_dmr_alu_tb
    import time_dmr_pkg::*;
();

    localparam int DataWidth   = DEFAULT_DATA_WIDTH;
    localparam int IdSize      = DEFAULT_ID_SIZE;
    localparam int PipeDepth   = DEFAULT_PIPE_DEPTH;
    localparam int ClkPeriod   = 20;
    localparam int ResetCycles = 10;

    // Requests per phase
    localparam int NumPlain  = 300;
    localparam int NumStall  = 200;
    localparam int NumFault  = 150;
    localparam int NumSingle = 100;
    localparam int NumTotal  = NumPlain + NumStall + NumFault + NumSingle;

    // Twenty cycles per request is far above the worst stalled latency
    localparam int TimeoutNs = (NumTotal * 20 + ResetCycles) * ClkPeriod;

    // Once back-pressure is off the last pair leaves well within this many cycles
    localparam int DrainCycles = 20;

    logic                 clk_i;
    logic                 reset_i;
    logic                 enable_i;
    logic                 fault_inject_i;
    alu_op_e              in_op_i;
    logic [DataWidth-1:0] in_a_i;
    logic [DataWidth-1:0] in_b_i;
    logic                 in_valid_i;
    logic                 in_ready_o;
    logic [DataWidth-1:0] out_data_o;
    logic [IdSize-1:0]    out_id_o;
    logic                 out_needs_retry_o;
    logic                 out_valid_o;
    logic                 out_ready_i;
    logic                 fault_detected_o;

    integer               seed = 43187;
    logic [DataWidth-1:0] exp_data_q[$];
    logic [IdSize-2:0]    exp_seq_q[$];
    logic [IdSize-2:0]    model_seq;
    int                   req_count;
    int                   out_count;
    int                   retry_count;
    int                   fault_pulses;
    bit                   fault_phase;

    time_dmr_alu #(
        .DataWidth(DataWidth),
        .IdSize(IdSize),
        .PipeDepth(PipeDepth)
    ) i_time_dmr_alu (
        .clk_i(clk_i),
        .reset_i(reset_i),
        .enable_i(enable_i),
        .fault_inject_i(fault_inject_i),
        .in_op_i(in_op_i),
        .in_a_i(in_a_i),
        .in_b_i(in_b_i),
        .in_valid_i(in_valid_i),
        .in_ready_o(in_ready_o),
        .out_data_o(out_data_o),
        .out_id_o(out_id_o),
        .out_needs_retry_o(out_needs_retry_o),
        .out_valid_o(out_valid_o),
        .out_ready_i(out_ready_i),
        .fault_detected_o(fault_detected_o)
    );

    bind time_dmr_end time_dmr_alu_assertions #(
        .DataWidth(DataWidth),
        .IdSize(IdSize)
    ) i_assertions (
        .clk_i(clk_i),
        .reset_i(reset_i),
        .state_i(state_q),
        .data_i(data_o),
        .id_i(id_o),
        .retry_i(needs_retry_o),
        .valid_i(valid_o),
        .ready_i(ready_i),
        .fault_i(fault_detected_o)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Model and checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("** Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, expected);
            $display("RESULT: FAIL");
            $fatal(1, "Mismatch on %s", what);
        end
    endtask

    function automatic int unsigned rand_below(input int unsigned limit);
        return $unsigned($random(seed)) % limit;
    endfunction

    // Reference ALU, shifts use the amount modulo the word width
    function automatic logic [DataWidth-1:0] model_result(input alu_op_e op,
            input logic [DataWidth-1:0] a, input logic [DataWidth-1:0] b);
        logic [2*DataWidth-1:0] product;
        int unsigned            shift;
        product = {{DataWidth{1'b0}}, a} * {{DataWidth{1'b0}}, b};
        shift   = b % DataWidth;
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            XOR:     return a ^ b;
            AND:     return a & b;
            SHL:     return a << shift;
            MUL_LO:  return product[DataWidth-1:0];
            default: return '0;
        endcase
    endfunction

    // Called on the cycle after a request was taken, while its payload still sits on the inputs
    task automatic expect_request();
        exp_data_q.push_back(model_result(in_op_i, in_a_i, in_b_i));
        // Sequence values count up one per request and wrap around
        exp_seq_q.push_back(model_seq);
        model_seq = model_seq + 1'b1;
        req_count++;
    endtask

    task automatic check_output();
        logic [DataWidth-1:0] exp_data;
        logic [IdSize-2:0]    exp_seq;
        check_value("request pending for output beat", exp_seq_q.size() != 0, 1);
        exp_data = exp_data_q.pop_front();
        exp_seq  = exp_seq_q.pop_front();
        check_value("out_id_o sequence", out_id_o[IdSize-2:0], exp_seq);
        // The top bit is the parity of the sequence bits, so the whole ID is even
        check_value("out_id_o parity", ^out_id_o, 0);
        if (out_needs_retry_o) begin
            // A flagged result may carry either copy, so only the flag is judged
            check_value("out_needs_retry_o", out_needs_retry_o, fault_phase);
            retry_count++;
        end else begin
            check_value("out_data_o", out_data_o, exp_data);
        end
        out_count++;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic run_phase(input int count, input bit stall, input bit faults,
                             input bit redundant);
        int          issued;
        int          fault_gap;
        int          drain;
        bit          sent;
        logic [31:0] rnd;
        logic [31:0] op_sel;
        issued    = 0;
        fault_gap = 5;
        @(negedge clk_i);
        enable_i    = redundant;
        fault_phase = faults;
        while (issued < count || in_valid_i) begin
            @(posedge clk_i);
            sent = in_valid_i & in_ready_o;
            @(negedge clk_i);
            if (sent) begin
                expect_request();
                in_valid_i = 1'b0;
            end
            // Fault runs keep the input busy, the others leave random gaps
            if (!in_valid_i && issued < count && (faults || rand_below(4) != 0)) begin
                rnd        = $random(seed);
                op_sel     = rand_below(6);
                in_op_i    = alu_op_e'(op_sel[2:0]);
                in_a_i     = rnd[DataWidth-1:0];
                in_b_i     = rnd[31:32-DataWidth];
                in_valid_i = 1'b1;
                issued++;
            end
            out_ready_i = stall ? (rand_below(3) != 0) : 1'b1;
            // Single-cycle upsets, at least ten cycles apart
            if (faults && fault_gap == 0) begin
                fault_inject_i = 1'b1;
                fault_gap      = 10 + rand_below(6);
            end else begin
                fault_inject_i = 1'b0;
                if (fault_gap > 0) begin
                    fault_gap--;
                end
            end
        end
        // Drain, then idle a while so a late duplicate would still show up
        fault_inject_i = 1'b0;
        out_ready_i    = 1'b1;
        drain          = 0;
        while (exp_seq_q.size() != 0 && drain < DrainCycles) begin
            @(negedge clk_i);
            drain++;
        end
        repeat (2 * PipeDepth + 4) @(negedge clk_i);
        check_value("outputs after phase", out_count, req_count);
        fault_phase = 1'b0;
    endtask

    initial begin : clock
        clk_i = 1'b0;
        forever #(ClkPeriod / 2) clk_i = ~clk_i;
    end

    // Outputs are sampled on the rising edge, inputs only move on the falling one
    initial begin : monitor
        forever begin
            @(posedge clk_i);
            if (!reset_i) begin
                if (fault_detected_o) begin
                    check_value("fault_detected_o", fault_detected_o, fault_phase);
                    fault_pulses++;
                end
                if (out_valid_o && out_ready_i) begin
                    check_output();
                end
            end
        end
    end

    initial begin : watchdog
        #(TimeoutNs);
        $display("Timeout: the run did not finish within %0d ns", TimeoutNs);
        $display("RESULT: FAIL");
        $fatal(1, "Watchdog expired");
    end

    initial begin : stimulus
        reset_i        = 1'b1;
        enable_i       = 1'b1;
        fault_inject_i = 1'b0;
        in_op_i        = ADD;
        in_a_i         = '0;
        in_b_i         = '0;
        in_valid_i     = 1'b0;
        out_ready_i    = 1'b1;
        model_seq      = '0;
        req_count      = 0;
        out_count      = 0;
        retry_count    = 0;
        fault_pulses   = 0;
        fault_phase    = 1'b0;
        repeat (ResetCycles) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;

        run_phase(NumPlain, 1'b0, 1'b0, 1'b1);
        run_phase(NumStall, 1'b1, 1'b0, 1'b1);
        run_phase(NumFault, 1'b0, 1'b1, 1'b1);
        // Redundancy off, each request passes once
        run_phase(NumSingle, 1'b1, 1'b0, 1'b0);

        if (retry_count > 0 && fault_pulses > 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("Injected faults gave %0d retry flags and %0d fault pulses, need both",
                     retry_count, fault_pulses);
            $display("RESULT: FAIL");
            $fatal(1, "Injected faults were not detected");
        end
    end

endmodule

// ==== time_dmr_alu.f ====
logic/time_dmr_pkg.sv
logic/time_dmr_start.sv
logic/alu_pipeline.sv
logic/time_dmr_end.sv
logic/time_dmr_alu.sv
testbench/time_dmr_alu_assertions.sv
testbench/time_dmr_alu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it
# The exit status is that of the simulation

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module time_dmr_alu_tb --Mdir obj_dir -f time_dmr_alu.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/Vtime_dmr_alu_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit $status
fi

exit 0
